// ==== common/avmm_rdwr_pkg.sv ====
// Avalon-style split read/write channel definitions
// Holds the bus widths and the request and response structs that
// travel between the master, the register stages and the memory.
// Waitrequest flows against the request direction and is kept out
// of these structs on purpose.

package avmm_rdwr_pkg;

    // Word address width, one address per data word
    localparam int ADDR_WIDTH = 10;

    // Data word width
    localparam int DATA_WIDTH = 32;

    // Burst count width; bursts of 1 to 8 words are used
    localparam int BURST_CNT_WIDTH = 4;

    // One byte enable per data byte
    localparam int BYTE_EN_WIDTH = DATA_WIDTH / 8;

    // Read request channel
    typedef struct packed {
        // High for one cycle per read command
        logic                       read;
        // Word address of the first beat
        logic [ADDR_WIDTH-1:0]      address;
        // Number of words returned for this command
        logic [BURST_CNT_WIDTH-1:0] burstcount;
    } rd_req_t;

    // Write request channel, one struct per write beat
    typedef struct packed {
        // High for every beat of a burst
        logic                       write;
        // Only meaningful on the first beat of a burst
        logic [ADDR_WIDTH-1:0]      address;
        // Only meaningful on the first beat of a burst
        logic [BURST_CNT_WIDTH-1:0] burstcount;
        logic [DATA_WIDTH-1:0]      writedata;
        logic [BYTE_EN_WIDTH-1:0]   byteenable;
    } wr_req_t;

    // Read response channel, one beat per burst word
    typedef struct packed {
        logic                  readdatavalid;
        logic [DATA_WIDTH-1:0] readdata;
    } rd_rsp_t;

    // Write response channel, one pulse per completed burst
    typedef struct packed {
        logic writeresponsevalid;
    } wr_rsp_t;

endpackage

// ==== design/avmm_rdwr_top.sv ====
// Top level of the split read/write memory channel
// The master ports pass through the register-stage pipeline and end
// at the queued on-chip memory. The queue margin covers every request
// that can be in flight in the request and waitrequest pipelines.

`timescale 1ns/1ps

module avmm_rdwr_top
#(
    parameter int N_REG_STAGES = 2,
    parameter int N_WAITREQUEST_STAGES = N_REG_STAGES,
    parameter int QUEUE_DEPTH = 16
)
(
    input  logic                   mem_slave,
    input  logic                   rst,
    input  avmm_rdwr_pkg::rd_req_t rd_req,
    input  avmm_rdwr_pkg::wr_req_t wr_req,
    output avmm_rdwr_pkg::rd_rsp_t rd_rsp,
    output avmm_rdwr_pkg::wr_rsp_t wr_rsp,
    output logic                   rd_waitrequest,
    output logic                   wr_waitrequest
);

    // Requests in the stages, those accepted while waitrequest travels
    // back, plus two for the registered flag and the entry mask
    localparam int ALMOST_FULL_MARGIN = N_REG_STAGES + N_WAITREQUEST_STAGES + 2;

    avmm_rdwr_pkg::rd_req_t dev_rd_req;
    avmm_rdwr_pkg::wr_req_t dev_wr_req;
    avmm_rdwr_pkg::rd_rsp_t dev_rd_rsp;
    avmm_rdwr_pkg::wr_rsp_t dev_wr_rsp;
    logic                   dev_rd_waitrequest;
    logic                   dev_wr_waitrequest;

    avmm_rdwr_reg_stages
    #(
        .N_REG_STAGES(N_REG_STAGES),
        .N_WAITREQUEST_STAGES(N_WAITREQUEST_STAGES)
    )
    stages
    (
        .mem_slave,
        .rst,
        .host_rd_req(rd_req),
        .host_wr_req(wr_req),
        .host_rd_rsp(rd_rsp),
        .host_wr_rsp(wr_rsp),
        .host_rd_waitrequest(rd_waitrequest),
        .host_wr_waitrequest(wr_waitrequest),
        .dev_rd_req,
        .dev_wr_req,
        .dev_rd_rsp,
        .dev_wr_rsp,
        .dev_rd_waitrequest,
        .dev_wr_waitrequest
    );

    avmm_rdwr_mem
    #(
        .QUEUE_DEPTH(QUEUE_DEPTH),
        .ALMOST_FULL_MARGIN(ALMOST_FULL_MARGIN)
    )
    mem
    (
        .mem_slave,
        .rst,
        .rd_req(dev_rd_req),
        .wr_req(dev_wr_req),
        .rd_rsp(dev_rd_rsp),
        .wr_rsp(dev_wr_rsp),
        .rd_waitrequest(dev_rd_waitrequest),
        .wr_waitrequest(dev_wr_waitrequest)
    );

endmodule

// ==== mem/avmm_rdwr_mem.sv ====
// On-chip memory slave for the split read/write channel
// Each channel lands in its own request queue, whose almost-full
// flag is the channel's waitrequest. A read sequencer turns one
// command into burstcount data beats; a write sequencer stores one
// beat per cycle and pulses a single response per burst.

`timescale 1ns/1ps

module avmm_rdwr_mem
#(
    parameter int QUEUE_DEPTH = 16,
    parameter int ALMOST_FULL_MARGIN = 6
)
(
    input  logic                   mem_slave,
    input  logic                   rst,
    input  avmm_rdwr_pkg::rd_req_t rd_req,
    input  avmm_rdwr_pkg::wr_req_t wr_req,
    output avmm_rdwr_pkg::rd_rsp_t rd_rsp,
    output avmm_rdwr_pkg::wr_rsp_t wr_rsp,
    output logic                   rd_waitrequest,
    output logic                   wr_waitrequest
);

    localparam int AW = avmm_rdwr_pkg::ADDR_WIDTH;
    localparam int DW = avmm_rdwr_pkg::DATA_WIDTH;
    localparam int BW = avmm_rdwr_pkg::BURST_CNT_WIDTH;
    localparam int BEW = avmm_rdwr_pkg::BYTE_EN_WIDTH;

    logic [DW-1:0] mem_array [2**AW];

    avmm_rdwr_pkg::rd_req_t rd_head;
    avmm_rdwr_pkg::wr_req_t wr_head;
    logic                   rd_empty;
    logic                   wr_empty;
    logic                   rd_pop;
    logic                   wr_pop;

    avmm_rdwr_req_queue
    #(
        .DEPTH(QUEUE_DEPTH),
        .ENTRY_WIDTH($bits(avmm_rdwr_pkg::rd_req_t)),
        .ALMOST_FULL_MARGIN(ALMOST_FULL_MARGIN)
    )
    rd_queue
    (
        .mem_slave,
        .rst,
        .push(rd_req.read),
        .push_data(rd_req),
        .pop(rd_pop),
        .pop_data(rd_head),
        .empty(rd_empty),
        .almost_full(rd_waitrequest)
    );

    avmm_rdwr_req_queue
    #(
        .DEPTH(QUEUE_DEPTH),
        .ENTRY_WIDTH($bits(avmm_rdwr_pkg::wr_req_t)),
        .ALMOST_FULL_MARGIN(ALMOST_FULL_MARGIN)
    )
    wr_queue
    (
        .mem_slave,
        .rst,
        .push(wr_req.write),
        .push_data(wr_req),
        .pop(wr_pop),
        .pop_data(wr_head),
        .empty(wr_empty),
        .almost_full(wr_waitrequest)
    );

    // Read sequencer state
    logic          rd_active;
    logic [AW-1:0] rd_addr;
    logic [BW-1:0] rd_left;
    logic          rd_valid_q;
    logic [DW-1:0] rd_data_q;

    // The next command is taken while the last beat of the current one
    // issues, so consecutive bursts stream without a gap
    assign rd_pop = !rd_empty && (!rd_active || (rd_left == BW'(1)));

    always_ff @(posedge mem_slave)
    begin
        if (rst)
        begin
            rd_active <= 1'b0;
            rd_valid_q <= 1'b0;
        end
        else
        begin
            rd_valid_q <= rd_active;
            if (rd_pop)
            begin
                rd_active <= 1'b1;
                rd_addr <= rd_head.address;
                rd_left <= rd_head.burstcount;
            end
            else if (rd_active)
            begin
                rd_addr <= rd_addr + 1'b1;
                rd_left <= rd_left - 1'b1;
                rd_active <= (rd_left != BW'(1));
            end
        end
    end

    // Array read in the cycle after the pop lands as a beat one cycle later
    always_ff @(posedge mem_slave)
    begin
        rd_data_q <= mem_array[rd_addr];
    end

    always_comb
    begin
        rd_rsp.readdatavalid = rd_valid_q;
        rd_rsp.readdata = rd_data_q;
    end

    // Write sequencer; the first beat of a burst carries address and count
    logic          wr_in_burst;
    logic [AW-1:0] wr_addr;
    logic [BW-1:0] wr_left;
    logic [AW-1:0] wr_beat_addr;
    logic [BW-1:0] wr_beat_left;
    logic          wr_rsp_q;

    assign wr_pop = !wr_empty;

    always_comb
    begin
        wr_beat_addr = wr_in_burst ? wr_addr : wr_head.address;
        wr_beat_left = wr_in_burst ? wr_left : wr_head.burstcount;
    end

    always_ff @(posedge mem_slave)
    begin
        if (wr_pop)
        begin
            for (int b = 0; b < BEW; b++)
            begin
                if (wr_head.byteenable[b])
                    mem_array[wr_beat_addr][b*8 +: 8] <= wr_head.writedata[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge mem_slave)
    begin
        if (rst)
        begin
            wr_in_burst <= 1'b0;
            wr_rsp_q <= 1'b0;
        end
        else
        begin
            // Response shows up the cycle after the last beat is stored
            wr_rsp_q <= wr_pop && (wr_beat_left == BW'(1));
            if (wr_pop)
            begin
                wr_in_burst <= (wr_beat_left != BW'(1));
                wr_addr <= wr_beat_addr + 1'b1;
                wr_left <= wr_beat_left - 1'b1;
            end
        end
    end

    assign wr_rsp.writeresponsevalid = wr_rsp_q;

endmodule

// ==== mem/avmm_rdwr_req_queue.sv ====
// Request queue for the memory slave
// A circular FIFO with a show-ahead head entry. The almost_full flag
// is registered and rises once the free slots drop to the margin,
// leaving room for every request still in flight upstream.

`timescale 1ns/1ps

module avmm_rdwr_req_queue
#(
    parameter int DEPTH = 16,
    parameter int ENTRY_WIDTH = 8,
    parameter int ALMOST_FULL_MARGIN = 4
)
(
    input  logic                   mem_slave,
    input  logic                   rst,
    input  logic                   push,
    input  logic [ENTRY_WIDTH-1:0] push_data,
    input  logic                   pop,
    output logic [ENTRY_WIDTH-1:0] pop_data,
    output logic                   empty,
    output logic                   almost_full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [ENTRY_WIDTH-1:0] storage [DEPTH];
    logic [PTR_W-1:0]       wr_ptr;
    logic [PTR_W-1:0]       rd_ptr;
    logic [CNT_W-1:0]       count;
    logic [CNT_W-1:0]       count_next;
    logic [CNT_W-1:0]       free_next;
    logic                   pop_ok;

    // A pop on an empty queue is ignored
    assign pop_ok = pop && !empty;
    assign empty = (count == '0);
    assign pop_data = storage[rd_ptr];

    always_comb
    begin
        count_next = count;
        if (push && !pop_ok)
            count_next = count + 1'b1;
        else if (!push && pop_ok)
            count_next = count - 1'b1;
        free_next = CNT_W'(DEPTH) - count_next;
    end

    always_ff @(posedge mem_slave)
    begin
        if (push)
            storage[wr_ptr] <= push_data;
    end

    always_ff @(posedge mem_slave)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            almost_full <= 1'b0;
        end
        else
        begin
            if (push)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop_ok)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            count <= count_next;
            // Flag looks at next cycle's occupancy so it is never late by one
            almost_full <= (free_next <= CNT_W'(ALMOST_FULL_MARGIN));
        end
    end

    // A push into a full queue means the upstream pipeline held more
    // requests than the margin allowed for
    no_overflow: assert property (@(posedge mem_slave) disable iff (rst)
        push |-> (count < CNT_W'(DEPTH)) || pop)
        else $error("request queue overflow, almost-full margin too small");

endmodule

// ==== reg_stages/avmm_rdwr_reg_stages.sv ====
// Register stages for a split read/write Avalon-style channel
// Requests and responses each pass through N_REG_STAGES flops.
// Waitrequest is not a handshake here. It is an almost-full flag
// delayed by its own shift register, so the slave must absorb every
// request already in flight when it raises waitrequest.

`timescale 1ns/1ps

module avmm_rdwr_reg_stages
#(
    parameter int N_REG_STAGES = 1,
    parameter int N_WAITREQUEST_STAGES = N_REG_STAGES
)
(
    input  logic                   mem_slave,
    input  logic                   rst,

    // Master side
    input  avmm_rdwr_pkg::rd_req_t host_rd_req,
    input  avmm_rdwr_pkg::wr_req_t host_wr_req,
    output avmm_rdwr_pkg::rd_rsp_t host_rd_rsp,
    output avmm_rdwr_pkg::wr_rsp_t host_wr_rsp,
    output logic                   host_rd_waitrequest,
    output logic                   host_wr_waitrequest,

    // Memory side
    output avmm_rdwr_pkg::rd_req_t dev_rd_req,
    output avmm_rdwr_pkg::wr_req_t dev_wr_req,
    input  avmm_rdwr_pkg::rd_rsp_t dev_rd_rsp,
    input  avmm_rdwr_pkg::wr_rsp_t dev_wr_rsp,
    input  logic                   dev_rd_waitrequest,
    input  logic                   dev_wr_waitrequest
);

    avmm_rdwr_pkg::rd_req_t rd_req_entry;
    avmm_rdwr_pkg::wr_req_t wr_req_entry;

    // A request offered while the master sees waitrequest is dropped here
    always_comb
    begin
        rd_req_entry = host_rd_req;
        rd_req_entry.read = host_rd_req.read && !host_rd_waitrequest;
        wr_req_entry = host_wr_req;
        wr_req_entry.write = host_wr_req.write && !host_wr_waitrequest;
    end

    generate
        if (N_REG_STAGES == 0)
        begin : wires
            // No stages requested, so both directions are plain connections
            assign dev_rd_req = rd_req_entry;
            assign dev_wr_req = wr_req_entry;
            assign host_rd_rsp = dev_rd_rsp;
            assign host_wr_rsp = dev_wr_rsp;
        end
        else
        begin : regs
            // Stage 1 is nearest its source; the last stage drives the far side
            avmm_rdwr_pkg::rd_req_t rd_req_pipe [1:N_REG_STAGES];
            avmm_rdwr_pkg::wr_req_t wr_req_pipe [1:N_REG_STAGES];
            avmm_rdwr_pkg::rd_rsp_t rd_rsp_pipe [1:N_REG_STAGES];
            avmm_rdwr_pkg::wr_rsp_t wr_rsp_pipe [1:N_REG_STAGES];

            always_ff @(posedge mem_slave)
            begin
                rd_req_pipe[1] <= rd_req_entry;
                wr_req_pipe[1] <= wr_req_entry;
                rd_rsp_pipe[1] <= dev_rd_rsp;
                wr_rsp_pipe[1] <= dev_wr_rsp;
                for (int s = 2; s <= N_REG_STAGES; s++)
                begin
                    rd_req_pipe[s] <= rd_req_pipe[s-1];
                    wr_req_pipe[s] <= wr_req_pipe[s-1];
                    rd_rsp_pipe[s] <= rd_rsp_pipe[s-1];
                    wr_rsp_pipe[s] <= wr_rsp_pipe[s-1];
                end

                // Only the valid bits are cleared, payload just shifts along
                if (rst)
                begin
                    for (int s = 1; s <= N_REG_STAGES; s++)
                    begin
                        rd_req_pipe[s].read <= 1'b0;
                        wr_req_pipe[s].write <= 1'b0;
                        rd_rsp_pipe[s].readdatavalid <= 1'b0;
                        wr_rsp_pipe[s].writeresponsevalid <= 1'b0;
                    end
                end
            end

            assign dev_rd_req = rd_req_pipe[N_REG_STAGES];
            assign dev_wr_req = wr_req_pipe[N_REG_STAGES];
            assign host_rd_rsp = rd_rsp_pipe[N_REG_STAGES];
            assign host_wr_rsp = wr_rsp_pipe[N_REG_STAGES];

            // The preset waitrequest needs N_WAITREQUEST_STAGES cycles to clear
            // and an accepted request needs N_REG_STAGES more to cross, so no
            // request may reach the memory within that window after reset
            rd_req_held_after_reset: assert property (@(posedge mem_slave) disable iff (rst)
                dev_rd_req.read |-> !$past(rst, N_REG_STAGES + N_WAITREQUEST_STAGES))
                else $error("read request reached memory while waitrequest was still preset");

            wr_req_held_after_reset: assert property (@(posedge mem_slave) disable iff (rst)
                dev_wr_req.write |-> !$past(rst, N_REG_STAGES + N_WAITREQUEST_STAGES))
                else $error("write request reached memory while waitrequest was still preset");
        end

        if (N_WAITREQUEST_STAGES == 0)
        begin : wait_wires
            assign host_rd_waitrequest = dev_rd_waitrequest;
            assign host_wr_waitrequest = dev_wr_waitrequest;
        end
        else
        begin : wait_regs
            // The memory-side flag enters at bit 0 and leaves at the top bit
            logic [N_WAITREQUEST_STAGES-1:0] rd_wait_sr;
            logic [N_WAITREQUEST_STAGES-1:0] wr_wait_sr;
            logic [N_WAITREQUEST_STAGES:0]   rd_wait_shift;
            logic [N_WAITREQUEST_STAGES:0]   wr_wait_shift;

            assign rd_wait_shift = {rd_wait_sr, dev_rd_waitrequest};
            assign wr_wait_shift = {wr_wait_sr, dev_wr_waitrequest};

            // Preset high so the master is held off until the memory speaks
            always_ff @(posedge mem_slave)
            begin
                if (rst)
                begin
                    rd_wait_sr <= '1;
                    wr_wait_sr <= '1;
                end
                else
                begin
                    rd_wait_sr <= rd_wait_shift[N_WAITREQUEST_STAGES-1:0];
                    wr_wait_sr <= wr_wait_shift[N_WAITREQUEST_STAGES-1:0];
                end
            end

            assign host_rd_waitrequest = rd_wait_sr[N_WAITREQUEST_STAGES-1];
            assign host_wr_waitrequest = wr_wait_sr[N_WAITREQUEST_STAGES-1];
        end
    endgenerate

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Compiles the memory channel testbench with Verilator and runs it.
# The run passes only if the log holds the testbench's pass line.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=avmm_rdwr_sim
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f sim.f \
    --top-module avmm_rdwr_tb \
    -Mdir "$BUILD_DIR" \
    -o "$SIM_BIN"
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^STATUS: PASS$" "$LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see $LOG"
    exit 1
fi

// ==== sim.f ====
common/avmm_rdwr_pkg.sv
reg_stages/avmm_rdwr_reg_stages.sv
mem/avmm_rdwr_req_queue.sv
mem/avmm_rdwr_mem.sv
design/avmm_rdwr_top.sv
tb/avmm_rdwr_tb.sv

// ==== tb/avmm_rdwr_tb.sv ====
// Testbench for the split read/write memory channel
// Replays a table of write bursts, read bursts and drain points
// against the top level. A byte-merged reference copy of the memory
// supplies the expected read words; write responses are counted
// against the write bursts in the table.

`timescale 1ns/1ps

module avmm_rdwr_tb;

    localparam int AW = avmm_rdwr_pkg::ADDR_WIDTH;
    localparam int DW = avmm_rdwr_pkg::DATA_WIDTH;
    localparam int BW = avmm_rdwr_pkg::BURST_CNT_WIDTH;
    localparam int BEW = avmm_rdwr_pkg::BYTE_EN_WIDTH;
    localparam int N_REG_STAGES = 2;
    localparam int N_WAIT_STAGES = 2;
    localparam int QUEUE_DEPTH = 16;
    localparam int SLOT_LIMIT = 200;
    localparam int DRAIN_LIMIT = 1000;
    localparam logic [1:0] K_WR = 2'd0;
    localparam logic [1:0] K_RD = 2'd1;
    localparam logic [1:0] K_SYNC = 2'd2;

    // One table row; a sync row waits until every response is back
    typedef struct packed {
        logic [1:0]     kind;
        logic [AW-1:0]  addr;
        logic [BW-1:0]  len;
        logic [BEW-1:0] be;
        logic [DW-1:0]  seed;
    } op_t;

    logic                   mem_slave;
    logic                   rst;
    avmm_rdwr_pkg::rd_req_t rd_req;
    avmm_rdwr_pkg::wr_req_t wr_req;
    avmm_rdwr_pkg::rd_rsp_t rd_rsp;
    avmm_rdwr_pkg::wr_rsp_t wr_rsp;
    logic                   rd_waitrequest;
    logic                   wr_waitrequest;

    op_t           ops [$];
    logic [DW-1:0] ref_mem [2**AW];
    logic [DW-1:0] exp_rd [$];
    logic [DW-1:0] exp_word;
    int            err_count;
    int            rd_beats;
    int            rd_words;
    int            wr_rsps;
    int            wr_bursts;
    int            rd_wait_cycles;
    int            wr_rows;
    bit            timed_out;
    bit            watch_load;

    avmm_rdwr_top
    #(
        .N_REG_STAGES(N_REG_STAGES),
        .N_WAITREQUEST_STAGES(N_WAIT_STAGES),
        .QUEUE_DEPTH(QUEUE_DEPTH)
    )
    dut
    (
        .mem_slave,
        .rst,
        .rd_req,
        .wr_req,
        .rd_rsp,
        .wr_rsp,
        .rd_waitrequest,
        .wr_waitrequest
    );

    always #4 mem_slave = ~mem_slave;

    function automatic logic [DW-1:0] merge_bytes(input logic [DW-1:0] old_word,
                                                  input logic [DW-1:0] new_word,
                                                  input logic [BEW-1:0] be);
        logic [DW-1:0] result;
        result = old_word;
        for (int b = 0; b < BEW; b++)
        begin
            if (be[b])
                result[b*8 +: 8] = new_word[b*8 +: 8];
        end
        return result;
    endfunction

    task automatic check_word(input logic [DW-1:0] got, input logic [DW-1:0] exp,
                              input string what);
        assert (got === exp)
        else
        begin
            err_count++;
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        assert (got === exp)
        else
        begin
            err_count++;
            $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_int(input int got, input int exp, input string what);
        assert (got == exp)
        else
        begin
            err_count++;
            $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // Outputs that must hold while nothing has been issued yet
    task automatic check_quiet(input logic exp_wait);
        check_bit(rd_waitrequest, exp_wait, "read waitrequest");
        check_bit(wr_waitrequest, exp_wait, "write waitrequest");
        check_bit(rd_rsp.readdatavalid, 1'b0, "readdatavalid");
        check_bit(wr_rsp.writeresponsevalid, 1'b0, "writeresponsevalid");
    endtask

    task automatic add_op(input logic [1:0] kind, input logic [AW-1:0] addr,
                          input logic [BW-1:0] len, input logic [BEW-1:0] be,
                          input logic [DW-1:0] seed);
        op_t op;
        op.kind = kind;
        op.addr = addr;
        op.len = len;
        op.be = be;
        op.seed = seed;
        ops.push_back(op);
    endtask

    task automatic build_table();
        // Single word written, then read back on its own
        add_op(K_WR, 10'd10, 4'd1, 4'hf, 32'h0000_5a5a);
        add_op(K_SYNC, 10'd0, 4'd0, 4'h0, 32'h0);
        add_op(K_RD, 10'd10, 4'd1, 4'h0, 32'h0);
        add_op(K_SYNC, 10'd0, 4'd0, 4'h0, 32'h0);
        // Full bursts first so that partial enables merge into known bytes
        add_op(K_WR, 10'd32, 4'd8, 4'hf, 32'h1357_0000);
        add_op(K_WR, 10'd64, 4'd8, 4'hf, 32'h2468_0000);
        add_op(K_WR, 10'd32, 4'd8, 4'h5, 32'h00ff_00ff);
        add_op(K_WR, 10'd66, 4'd4, 4'hc, 32'hffff_0000);
        add_op(K_WR, 10'd35, 4'd3, 4'h2, 32'h0000_ff00);
        add_op(K_SYNC, 10'd0, 4'd0, 4'h0, 32'h0);
        add_op(K_RD, 10'd32, 4'd8, 4'h0, 32'h0);
        add_op(K_RD, 10'd64, 4'd8, 4'h0, 32'h0);
        add_op(K_RD, 10'd66, 4'd3, 4'h0, 32'h0);
        add_op(K_RD, 10'd10, 4'd1, 4'h0, 32'h0);
        add_op(K_SYNC, 10'd0, 4'd0, 4'h0, 32'h0);
        // Back to back writes over 128 to 151, then partial rewrites
        add_op(K_WR, 10'd128, 4'd8, 4'hf, 32'h3a3a_0000);
        add_op(K_WR, 10'd136, 4'd8, 4'hf, 32'h4b4b_0000);
        add_op(K_WR, 10'd144, 4'd8, 4'hf, 32'h5c5c_0000);
        add_op(K_WR, 10'd130, 4'd5, 4'h9, 32'h6d6d_0000);
        add_op(K_WR, 10'd145, 4'd2, 4'h6, 32'h7e7e_0000);
        add_op(K_SYNC, 10'd0, 4'd0, 4'h0, 32'h0);
        // Long read bursts at full rate fill the read queue until waitrequest rises
        for (int r = 0; r < 14; r++)
            add_op(K_RD, AW'(128 + 8 * (r % 3)), 4'd8, 4'h0, 32'h0);
        add_op(K_SYNC, 10'd0, 4'd0, 4'h0, 32'h0);
    endtask

    // Inputs change 1 ns after the edge; valids last for one cycle only
    task automatic next_cycle();
        @(posedge mem_slave);
        #1;
        rd_req.read = 1'b0;
        wr_req.write = 1'b0;
    endtask

    // Returns in a cycle where the channel's waitrequest is low
    task automatic wait_slot(input bit is_write, input string what);
        int   cycles;
        logic busy;
        cycles = 0;
        next_cycle();
        busy = is_write ? wr_waitrequest : rd_waitrequest;
        while (busy && !timed_out)
        begin
            cycles++;
            if (cycles >= SLOT_LIMIT)
            begin
                $display("Timed out: %s waitrequest stayed high for %0d cycles", what, cycles);
                timed_out = 1'b1;
            end
            else
            begin
                next_cycle();
                busy = is_write ? wr_waitrequest : rd_waitrequest;
            end
        end
    endtask

    task automatic drive_write_burst(input op_t op);
        logic [AW-1:0] a;
        logic [DW-1:0] word;
        for (int b = 0; b < int'(op.len); b++)
        begin
            if (!timed_out)
            begin
                word = $urandom() ^ op.seed;
                a = op.addr + AW'(b);
                wait_slot(1'b1, "write");
                if (!timed_out)
                begin
                    wr_req.write = 1'b1;
                    wr_req.address = op.addr;
                    wr_req.burstcount = op.len;
                    wr_req.writedata = word;
                    wr_req.byteenable = op.be;
                    // The reference follows the beat as soon as it is accepted
                    ref_mem[a] = merge_bytes(ref_mem[a], word, op.be);
                    if (b == int'(op.len) - 1)
                        wr_bursts++;
                end
            end
        end
    endtask

    task automatic drive_read(input op_t op);
        logic [AW-1:0] a;
        wait_slot(1'b0, "read");
        if (!timed_out)
        begin
            rd_req.read = 1'b1;
            rd_req.address = op.addr;
            rd_req.burstcount = op.len;
            for (int b = 0; b < int'(op.len); b++)
            begin
                a = op.addr + AW'(b);
                exp_rd.push_back(ref_mem[a]);
            end
            rd_words += int'(op.len);
        end
    endtask

    // Waits until every read word and write response issued so far is back
    task automatic wait_all_done();
        int cycles;
        cycles = 0;
        next_cycle();
        while ((exp_rd.size() != 0 || wr_rsps < wr_bursts) && !timed_out)
        begin
            cycles++;
            if (cycles >= DRAIN_LIMIT)
            begin
                $display("Timed out: %0d read words and %0d write responses still missing",
                         exp_rd.size(), wr_bursts - wr_rsps);
                timed_out = 1'b1;
            end
            else
                next_cycle();
        end
    endtask

    // Response monitor, sampling the registered outputs at the edge
    always @(posedge mem_slave)
    begin
        if (!rst && rd_rsp.readdatavalid)
        begin
            rd_beats++;
            assert (exp_rd.size() != 0)
            else
            begin
                err_count++;
                $display("ERR %0t: read beat arrived with no read outstanding", $time);
            end
            if (exp_rd.size() != 0)
            begin
                exp_word = exp_rd.pop_front();
                check_word(rd_rsp.readdata, exp_word, "read data");
            end
        end
        if (!rst && wr_rsp.writeresponsevalid)
            wr_rsps++;
        if (watch_load && rd_waitrequest)
            rd_wait_cycles++;
    end

    initial
    begin
        void'($urandom(32'h3995a140));
        mem_slave = 1'b0;
        rst = 1'b1;
        rd_req = '0;
        wr_req = '0;
        err_count = 0;
        rd_beats = 0;
        rd_words = 0;
        wr_rsps = 0;
        wr_bursts = 0;
        rd_wait_cycles = 0;
        wr_rows = 0;
        timed_out = 1'b0;
        watch_load = 1'b0;
        build_table();

        // Held off and silent for the whole reset
        for (int c = 0; c < 10; c++)
        begin
            next_cycle();
            check_quiet(1'b1);
        end
        rst = 1'b0;
        // Waitrequest drains out of its shift register in exactly that many cycles
        for (int k = 1; k <= N_WAIT_STAGES; k++)
        begin
            next_cycle();
            check_quiet(k < N_WAIT_STAGES);
        end
        watch_load = 1'b1;

        foreach (ops[i])
        begin
            if (!timed_out)
            begin
                case (ops[i].kind)
                    K_WR: drive_write_burst(ops[i]);
                    K_RD: drive_read(ops[i]);
                    default: wait_all_done();
                endcase
            end
        end

        if (!timed_out)
        begin
            wait_all_done();
            // Quiet window that would expose a late extra response
            repeat (20) next_cycle();
            foreach (ops[i])
            begin
                if (ops[i].kind == K_WR)
                    wr_rows++;
            end
            check_int(wr_rsps, wr_rows, "write responses against write bursts in the table");
            check_int(rd_beats, rd_words, "read beats against words requested");
            assert (rd_wait_cycles > 0)
            else
            begin
                err_count++;
                $display("ERR %0t: read waitrequest never rose under load", $time);
            end
        end

        $display("Errors: %0d, timeouts: %0d, read beats: %0d, write responses: %0d",
                 err_count, timed_out, rd_beats, wr_rsps);
        if (err_count == 0 && !timed_out)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule
